//--- source/rv32i_types.sv
package rv32i_types;

    // basic datapath widths
    typedef logic [31:0] word_t;
    typedef logic [5:0]  phys_reg_t;  // physical register number
    typedef logic [5:0]  rob_idx_t;   // reorder buffer entry

    // memory operation kind carried through the queue
    typedef enum logic {
        mem_load,
        mem_store
    } mem_op_t;

    // one slot of the in-order memory queue
    typedef struct packed {
        logic      valid;      // slot occupied
        logic      ready;      // address written by the agu
        logic      committed;  // store released by the rob
        mem_op_t   op;
        word_t     addr;
        word_t     wdata;
        phys_reg_t pd;         // load destination
        rob_idx_t  rob_num;
    } lsq_entry_t;

    // cache port handshake states
    typedef enum logic [1:0] {
        dp_idle,     // waiting for issue
        dp_req,      // mem_req high, waiting for ack
        dp_release,  // req dropped, waiting for ack to fall
        dp_done      // one cycle done pulse
    } dport_state_t;

endpackage

//--- source/dmem_if.sv
`timescale 1ns/100ps

// link between the memory queue head and the cache port
interface dmem_if;

    logic               issue;  // head entry eligible, request fields valid
    rv32i_types::word_t addr;
    logic [3:0]         wmask;
    logic [3:0]         rmask;
    rv32i_types::word_t wdata;
    rv32i_types::word_t rdata;  // valid with done
    logic               done;   // one cycle, transaction finished

    modport queue (
        output issue, addr, wmask, rmask, wdata,
        input  rdata, done
    );

    modport port (
        input  issue, addr, wmask, rmask, wdata,
        output rdata, done
    );

endinterface

//--- source/agu.sv
`timescale 1ns/100ps

module agu #(
    parameter int queue_depth = 16
) (
    input  logic                            clk,
    input  logic                            rst,

    input  logic                            in_valid,
    input  logic [$clog2(queue_depth)-1:0]  in_idx,
    input  rv32i_types::word_t              base,
    input  rv32i_types::word_t              offset,
    input  rv32i_types::word_t              in_wdata,

    output logic                            addr_valid,
    output logic [$clog2(queue_depth)-1:0]  addr_idx,
    output rv32i_types::word_t              addr,
    output rv32i_types::word_t              store_data
);

    // valid pulse follows the input by exactly one edge
    always_ff @(posedge clk) begin
        if (rst) begin
            addr_valid <= 1'b0;
        end else begin
            addr_valid <= in_valid;
        end
    end

    // result fields only move on an accepted input
    always_ff @(posedge clk) begin
        if (in_valid) begin
            addr       <= base + offset;  // no alignment check, words only
            addr_idx   <= in_idx;         // slot tag rides along
            store_data <= in_wdata;
        end
    end

endmodule

//--- source/memory_queue.sv
`timescale 1ns/100ps

module memory_queue #(
    parameter int queue_depth = 16
) (
    input  logic                            clk,
    input  logic                            rst,

    // dispatch, in program order
    input  logic                            disp_valid,
    input  rv32i_types::mem_op_t            disp_op,
    input  rv32i_types::phys_reg_t          disp_pd,
    input  rv32i_types::rob_idx_t           disp_rob,
    output logic [$clog2(queue_depth)-1:0]  disp_idx,
    output logic                            full,

    // agu results, any order
    input  logic                            addr_valid,
    input  logic [$clog2(queue_depth)-1:0]  addr_idx,
    input  rv32i_types::word_t              addr,
    input  rv32i_types::word_t              store_data,

    // rob commit
    input  logic                            commit_valid,
    input  rv32i_types::rob_idx_t           commit_rob,

    // towards the cache port
    dmem_if.queue                           dmem,

    // load writeback
    output logic                            load_valid,
    output rv32i_types::phys_reg_t          load_pd,
    output rv32i_types::word_t              load_data
);

    import rv32i_types::*;

    localparam int idx_w = $clog2(queue_depth);

    lsq_entry_t       q [queue_depth];

    logic [idx_w:0]   head;  // msb is the wrap bit
    logic [idx_w:0]   tail;
    logic [idx_w-1:0] head_slot;
    logic [idx_w-1:0] tail_slot;

    lsq_entry_t       head_entry;
    logic             head_eligible;
    logic             enq;
    logic             retire_q;  // done seen last cycle

    assign head_slot = head[idx_w-1:0];
    assign tail_slot = tail[idx_w-1:0];

    // same slot, different lap
    assign full     = (head_slot == tail_slot) && (head[idx_w] != tail[idx_w]);
    assign disp_idx = tail_slot;
    assign enq      = disp_valid && !full;

    assign head_entry = q[head_slot];

    // loads go once the address is in, stores also wait for commit
    assign head_eligible = head_entry.valid && head_entry.ready &&
                           (head_entry.op == mem_load || head_entry.committed);

    // one bubble after done so issue always falls between accesses
    assign dmem.issue = head_eligible && !retire_q;
    assign dmem.addr  = head_entry.addr;
    assign dmem.wdata = head_entry.wdata;
    assign dmem.rmask = (dmem.issue && head_entry.op == mem_load)  ? 4'hf : 4'h0;
    assign dmem.wmask = (dmem.issue && head_entry.op == mem_store) ? 4'hf : 4'h0;

    // load result leaves with done, store retires silently
    assign load_valid = dmem.done && (head_entry.op == mem_load);
    assign load_pd    = head_entry.pd;
    assign load_data  = dmem.rdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            head     <= '0;
            tail     <= '0;
            retire_q <= 1'b0;
        end else begin
            retire_q <= dmem.done;
            if (enq) begin
                tail <= tail + 1'b1;
            end
            if (dmem.done) begin
                head <= head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < queue_depth; i++) begin
                q[i].valid     <= 1'b0;
                q[i].ready     <= 1'b0;
                q[i].committed <= 1'b0;
            end
        end else begin
            if (enq) begin
                q[tail_slot].valid     <= 1'b1;
                q[tail_slot].ready     <= 1'b0;
                q[tail_slot].committed <= 1'b0;
                q[tail_slot].op        <= disp_op;
                q[tail_slot].pd        <= disp_pd;
                q[tail_slot].rob_num   <= disp_rob;
            end

            // slot already exists, so always taken
            if (addr_valid) begin
                q[addr_idx].addr  <= addr;
                q[addr_idx].wdata <= store_data;
                q[addr_idx].ready <= 1'b1;
            end

            // commit may land before or after the address
            for (int i = 0; i < queue_depth; i++) begin
                if (commit_valid && q[i].valid && q[i].op == mem_store &&
                    q[i].rob_num == commit_rob) begin
                    q[i].committed <= 1'b1;
                end
            end

            if (dmem.done) begin
                q[head_slot].valid     <= 1'b0;
                q[head_slot].ready     <= 1'b0;
                q[head_slot].committed <= 1'b0;
            end
        end
    end

endmodule

//--- source/dcache_port.sv
`timescale 1ns/100ps

module dcache_port (
    input  logic               clk,
    input  logic               rst,

    dmem_if.port               dmem,

    // four-phase link to data memory
    output logic               mem_req,
    output rv32i_types::word_t mem_addr,
    output rv32i_types::word_t mem_wdata,
    output logic [3:0]         mem_rmask,
    output logic [3:0]         mem_wmask,
    input  logic               mem_ack,
    input  rv32i_types::word_t mem_rdata
);

    import rv32i_types::*;

    dport_state_t state;

    // private copy of the request, stable for the whole exchange
    word_t        req_addr;
    word_t        req_wdata;
    logic [3:0]   req_rmask;
    logic [3:0]   req_wmask;
    word_t        rdata_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= dp_idle;
        end else begin
            case (state)
                dp_idle: begin
                    if (dmem.issue) begin
                        state <= dp_req;
                    end
                end
                dp_req: begin
                    if (mem_ack) begin
                        state <= dp_release;  // phase 3, drop req
                    end
                end
                dp_release: begin
                    if (!mem_ack) begin
                        state <= dp_done;     // memory finished phase 4
                    end
                end
                default: begin
                    state <= dp_idle;         // dp_done lasts one cycle
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == dp_idle && dmem.issue) begin
            req_addr  <= dmem.addr;
            req_wdata <= dmem.wdata;
            req_rmask <= dmem.rmask;
            req_wmask <= dmem.wmask;
        end
        if (state == dp_req && mem_ack) begin
            rdata_q <= mem_rdata;  // sampled with ack, held until done
        end
    end

    assign mem_req   = (state == dp_req);
    assign mem_addr  = req_addr;
    assign mem_wdata = req_wdata;
    assign mem_rmask = req_rmask;
    assign mem_wmask = req_wmask;

    assign dmem.done  = (state == dp_done);
    assign dmem.rdata = rdata_q;

endmodule

//--- source/lsq_top.sv
`timescale 1ns/100ps

module lsq_top #(
    parameter int queue_depth = 16
) (
    input  logic                            clk,
    input  logic                            rst,

    // dispatch
    input  logic                            disp_valid,
    input  rv32i_types::mem_op_t            disp_op,
    input  rv32i_types::phys_reg_t          disp_pd,
    input  rv32i_types::rob_idx_t           disp_rob,
    output logic [$clog2(queue_depth)-1:0]  disp_idx,
    output logic                            full,

    // address generation inputs
    input  logic                            in_valid,
    input  logic [$clog2(queue_depth)-1:0]  in_idx,
    input  rv32i_types::word_t              base,
    input  rv32i_types::word_t              offset,
    input  rv32i_types::word_t              in_wdata,

    // rob commit
    input  logic                            commit_valid,
    input  rv32i_types::rob_idx_t           commit_rob,

    // load writeback
    output logic                            load_valid,
    output rv32i_types::phys_reg_t          load_pd,
    output rv32i_types::word_t              load_data,

    // data memory
    output logic                            mem_req,
    output rv32i_types::word_t              mem_addr,
    output rv32i_types::word_t              mem_wdata,
    output logic [3:0]                      mem_rmask,
    output logic [3:0]                      mem_wmask,
    input  logic                            mem_ack,
    input  rv32i_types::word_t              mem_rdata
);

    import rv32i_types::*;

    localparam int idx_w = $clog2(queue_depth);

    // agu result towards the queue
    logic             addr_valid;
    logic [idx_w-1:0] addr_idx;
    word_t            agu_addr;
    word_t            store_data;

    dmem_if dmem_bus ();

    agu #(
        .queue_depth (queue_depth)
    ) u_agu (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_idx     (in_idx),
        .base       (base),
        .offset     (offset),
        .in_wdata   (in_wdata),
        .addr_valid (addr_valid),
        .addr_idx   (addr_idx),
        .addr       (agu_addr),
        .store_data (store_data)
    );

    memory_queue #(
        .queue_depth (queue_depth)
    ) u_queue (
        .clk          (clk),
        .rst          (rst),
        .disp_valid   (disp_valid),
        .disp_op      (disp_op),
        .disp_pd      (disp_pd),
        .disp_rob     (disp_rob),
        .disp_idx     (disp_idx),
        .full         (full),
        .addr_valid   (addr_valid),
        .addr_idx     (addr_idx),
        .addr         (agu_addr),
        .store_data   (store_data),
        .commit_valid (commit_valid),
        .commit_rob   (commit_rob),
        .dmem         (dmem_bus.queue),
        .load_valid   (load_valid),
        .load_pd      (load_pd),
        .load_data    (load_data)
    );

    dcache_port u_dport (
        .clk       (clk),
        .rst       (rst),
        .dmem      (dmem_bus.port),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rmask (mem_rmask),
        .mem_wmask (mem_wmask),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

endmodule

//--- bench/lsq_chk.sv
`timescale 1ns/100ps

module lsq_chk (
    input logic               clk,
    input logic               rst,
    input logic               mem_req,
    input logic               mem_ack,
    input rv32i_types::word_t mem_addr,
    input rv32i_types::word_t mem_wdata,
    input logic [3:0]         mem_rmask,
    input logic [3:0]         mem_wmask,
    input logic               load_valid
);

    int fail_count = 0;  // read by the testbench

    req_held: assert property (@(posedge clk) disable iff (rst)
        mem_req && !mem_ack |=> mem_req)
        else begin
            $error("mem_req dropped before mem_ack");
            fail_count++;
        end

    // request fields frozen for the whole phase 1
    req_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req && $past(mem_req) |-> $stable(mem_addr) && $stable(mem_wdata) &&
                                      $stable(mem_rmask) && $stable(mem_wmask))
        else begin
            $error("request fields changed while mem_req high");
            fail_count++;
        end

    ack_after_req: assert property (@(posedge clk) disable iff (rst)
        $rose(mem_ack) |-> mem_req)
        else begin
            $error("mem_ack rose without mem_req");
            fail_count++;
        end

    one_mask: assert property (@(posedge clk) disable iff (rst)
        mem_req |-> (mem_rmask != 4'h0) != (mem_wmask != 4'h0))
        else begin
            $error("read and write masks both set or both clear");
            fail_count++;
        end

    no_load_in_reset: assert property (@(posedge clk)
        rst && $past(rst) |-> !load_valid)
        else begin
            $error("load_valid high during reset");
            fail_count++;
        end

endmodule

bind lsq_top lsq_chk u_chk (
    .clk        (clk),
    .rst        (rst),
    .mem_req    (mem_req),
    .mem_ack    (mem_ack),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_rmask  (mem_rmask),
    .mem_wmask  (mem_wmask),
    .load_valid (load_valid)
);

//--- bench/lsq_tb.sv
`timescale 1ns/100ps

module lsq_tb;

    import rv32i_types::*;

    localparam int    depth          = 16;
    localparam int    idx_w          = $clog2(depth);
    localparam int    timeout_cycles = 2000;
    localparam word_t mem_base       = 32'h1000_0000;

    logic             clk;
    logic             rst;
    logic             disp_valid;
    mem_op_t          disp_op;
    phys_reg_t        disp_pd;
    rob_idx_t         disp_rob;
    logic [idx_w-1:0] disp_idx;
    logic             full;
    logic             in_valid;
    logic [idx_w-1:0] in_idx;
    word_t            base;
    word_t            offset;
    word_t            in_wdata;
    logic             commit_valid;
    rob_idx_t         commit_rob;
    logic             load_valid;
    phys_reg_t        load_pd;
    word_t            load_data;
    logic             mem_req;
    logic             mem_ack;
    word_t            mem_addr;
    word_t            mem_wdata;
    word_t            mem_rdata;
    logic [3:0]       mem_rmask;
    logic [3:0]       mem_wmask;

    word_t mem [word_t];      // data memory model
    word_t ref_mem [word_t];  // what memory should hold, in program order

    // every dispatched op, index doubles as rob number
    mem_op_t   sh_op [$];
    word_t     sh_addr [$];
    word_t     sh_wdata [$];
    phys_reg_t sh_pd [$];
    int        sh_slot [$];
    int        ref_ptr    = 0;
    int        loads_done = 0;
    int        loads_sent = 0;
    int        disp_count = 0;

    lsq_top #(.queue_depth(depth)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic word_t fill_word(word_t a);
        return {a[15:0], a[31:16]} ^ 32'h9e37_79b9;
    endfunction

    task automatic stop_run(string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(word_t got, word_t exp, string what);
        if (got !== exp) begin
            stop_run($sformatf("Mismatch at %0t: %s got %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_pd(phys_reg_t got, phys_reg_t exp, string what);
        if (got !== exp) begin
            stop_run($sformatf("Mismatch at %0t: %s got %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic check_slot(logic [idx_w-1:0] got, logic [idx_w-1:0] exp, string what);
        if (got !== exp) begin
            stop_run($sformatf("Mismatch at %0t: %s got %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        if (got !== exp) begin
            stop_run($sformatf("Mismatch at %0t: %s got %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_mask(logic [3:0] got, logic [3:0] exp, string what);
        if (got !== exp) begin
            stop_run($sformatf("Mismatch at %0t: %s got %h, expected %h", $time, what, got, exp));
        end
    endtask

    // replays stores in order up to the next load
    function automatic void expect_load(output word_t data, output phys_reg_t pd, output bit found);
        found = 1'b0;
        data  = '0;
        pd    = '0;
        while (ref_ptr < sh_op.size() && !found) begin
            if (sh_op[ref_ptr] == mem_store) begin
                ref_mem[sh_addr[ref_ptr]] = sh_wdata[ref_ptr];
            end else begin
                data  = ref_mem[sh_addr[ref_ptr]];
                pd    = sh_pd[ref_ptr];
                found = 1'b1;
            end
            ref_ptr++;
        end
    endfunction

    // load results, sampled at the edge that ends their cycle
    always @(posedge clk) begin
        word_t     exp_data;
        phys_reg_t exp_pd;
        bit        found;
        if (!rst && load_valid) begin
            expect_load(exp_data, exp_pd, found);
            if (!found) begin
                stop_run("load result appeared with no load left in program order");
            end
            check_pd(load_pd, exp_pd, "load pd");
            check_word(load_data, exp_data, "load data");
            loads_done++;
        end
    end

    always @(negedge clk) begin
        if (dut.u_chk.fail_count != 0) begin
            stop_run("a handshake assertion failed");
        end
    end

    // four-phase responder with random ack delay
    initial begin
        int delay;
        int t;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        forever begin
            @(posedge clk);
            if (mem_req && !mem_ack) begin
                delay = $urandom_range(5, 0);
                repeat (delay) @(posedge clk);
                if (mem_wmask != 4'h0) begin
                    check_mask(mem_wmask, 4'hf, "write mask");  // full words only
                    mem[mem_addr] = mem_wdata;  // write lands with ack
                end else begin
                    check_mask(mem_rmask, 4'hf, "read mask");
                    mem_rdata <= mem[mem_addr];
                end
                mem_ack <= 1'b1;
                t = 0;
                do begin
                    @(posedge clk);
                    t++;
                    if (t > timeout_cycles) begin
                        stop_run("mem_req never dropped after mem_ack");
                    end
                end while (mem_req);
                mem_ack <= 1'b0;
            end
        end
    end

    task automatic dispatch(mem_op_t op, word_t a, word_t wd, phys_reg_t pd);
        int t;
        t = 0;
        @(negedge clk);
        while (full) begin
            @(negedge clk);
            t++;
            if (t > timeout_cycles) begin
                stop_run("queue stayed full and dispatch could not proceed");
            end
        end
        check_slot(disp_idx, idx_w'(disp_count), "dispatch slot");  // wraps modulo depth
        sh_op.push_back(op);
        sh_addr.push_back(a);
        sh_wdata.push_back(wd);
        sh_pd.push_back(pd);
        sh_slot.push_back(int'(disp_idx));
        @(posedge clk);
        disp_valid <= 1'b1;
        disp_op    <= op;
        disp_pd    <= pd;
        disp_rob   <= rob_idx_t'(disp_count);
        @(posedge clk);
        disp_valid <= 1'b0;
        disp_count++;
        if (op == mem_load) begin
            loads_sent++;
        end
    endtask

    // random offset, base picked so the sum is the wanted address
    task automatic send_addr(int i);
        word_t off;
        off = $urandom();
        @(posedge clk);
        in_valid <= 1'b1;
        in_idx   <= idx_w'(sh_slot[i]);
        base     <= sh_addr[i] - off;
        offset   <= off;
        in_wdata <= sh_wdata[i];
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic commit(int i);
        @(posedge clk);
        commit_valid <= 1'b1;
        commit_rob   <= rob_idx_t'(i);
        @(posedge clk);
        commit_valid <= 1'b0;
    endtask

    task automatic wait_loads(int n);
        int t;
        t = 0;
        while (loads_done < n) begin
            @(negedge clk);
            t++;
            if (t > timeout_cycles) begin
                stop_run("load results did not arrive in time");
            end
        end
    endtask

    initial begin
        int      first;
        int      k;
        int      iter;
        int      issued;
        int      pend_addr [$];
        int      pend_commit [$];
        mem_op_t op;

        void'($urandom(62238));
        rst          = 1'b1;
        disp_valid   = 1'b0;
        disp_op      = mem_load;
        disp_pd      = '0;
        disp_rob     = '0;
        in_valid     = 1'b0;
        in_idx       = '0;
        base         = '0;
        offset       = '0;
        in_wdata     = '0;
        commit_valid = 1'b0;
        commit_rob   = '0;
        for (int i = 0; i < 16; i++) begin
            mem[mem_base + word_t'(4 * i)]     = fill_word(mem_base + word_t'(4 * i));
            ref_mem[mem_base + word_t'(4 * i)] = fill_word(mem_base + word_t'(4 * i));
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // plain loads from preloaded words
        first = sh_op.size();
        for (int i = 0; i < 4; i++) begin
            dispatch(mem_load, mem_base + word_t'(4 * i), '0, phys_reg_t'(i + 1));
        end
        for (int i = 0; i < 4; i++) begin
            send_addr(first + i);
        end
        wait_loads(loads_sent);

        // store then load of the same word
        first = sh_op.size();
        dispatch(mem_store, mem_base + 32'h20, 32'hcafe_f00d, '0);
        dispatch(mem_load, mem_base + 32'h20, '0, 6'd9);
        send_addr(first);
        send_addr(first + 1);
        commit(first);
        wait_loads(loads_sent);
        check_word(mem[mem_base + 32'h20], 32'hcafe_f00d, "memory word after store");

        // head store holds everything back until commit
        first = sh_op.size();
        dispatch(mem_store, mem_base + 32'h24, 32'h0bad_beef, '0);
        dispatch(mem_load, mem_base + 32'h24, '0, 6'd11);
        dispatch(mem_load, mem_base + 32'h00, '0, 6'd12);
        for (int i = 0; i < 3; i++) begin
            send_addr(first + i);
        end
        for (int c = 0; c < 20; c++) begin
            @(negedge clk);
            if (mem_req && mem_wmask != 4'h0) begin
                stop_run("uncommitted store reached the memory");
            end
            if (load_valid) begin
                stop_run("load completed behind an uncommitted store");
            end
        end
        commit(first);
        wait_loads(loads_sent);

        // addresses in reverse dispatch order
        first = sh_op.size();
        dispatch(mem_load, mem_base + 32'h10, '0, 6'd20);
        dispatch(mem_store, mem_base + 32'h14, 32'h1234_5678, '0);
        dispatch(mem_load, mem_base + 32'h14, '0, 6'd21);
        dispatch(mem_load, mem_base + 32'h08, '0, 6'd22);
        commit(first + 1);
        for (int i = 3; i >= 0; i--) begin
            send_addr(first + i);
        end
        wait_loads(loads_sent);

        // fill every slot, then drain one
        first = sh_op.size();
        for (int i = 0; i < depth; i++) begin
            dispatch(mem_load, mem_base + word_t'(4 * (i % 16)), '0, phys_reg_t'(32 + i));
        end
        @(negedge clk);
        check_flag(full, 1'b1, "full after sixteen dispatches");
        check_slot(disp_idx, idx_w'(disp_count), "wrapped dispatch slot");
        send_addr(first);
        wait_loads(loads_sent - depth + 1);
        check_flag(full, 1'b0, "full after head completed");
        for (int i = 1; i < depth; i++) begin
            send_addr(first + i);
        end
        wait_loads(loads_sent);

        // random mix, address and commit order shuffled
        issued = 0;
        iter   = 0;
        while (issued < 120 || pend_addr.size() > 0 || pend_commit.size() > 0) begin
            @(negedge clk);
            iter++;
            if (iter > 20 * timeout_cycles) begin
                stop_run("random traffic did not finish");
            end
            k = $urandom_range(2, 0);
            if (k == 0 && issued < 120 && !full) begin
                op = ($urandom_range(1, 0) == 1) ? mem_store : mem_load;
                dispatch(op, mem_base + word_t'(4 * $urandom_range(15, 0)), $urandom(),
                         phys_reg_t'($urandom()));
                pend_addr.push_back(sh_op.size() - 1);
                if (op == mem_store) begin
                    pend_commit.push_back(sh_op.size() - 1);
                end
                issued++;
            end else if (k == 1 && pend_addr.size() > 0) begin
                k = $urandom_range(pend_addr.size() - 1, 0);
                send_addr(pend_addr[k]);
                pend_addr.delete(k);
            end else if (k == 2 && pend_commit.size() > 0) begin
                k = $urandom_range(pend_commit.size() - 1, 0);
                commit(pend_commit[k]);
                pend_commit.delete(k);
            end
        end
        // trailing load pushes the last stores out
        dispatch(mem_load, mem_base, '0, 6'd63);
        send_addr(sh_op.size() - 1);
        wait_loads(loads_sent);

        if (dut.u_chk.fail_count == 0) begin
            $display("No errors");
            $finish;
        end else begin
            stop_run("a handshake assertion failed");
        end
    end

endmodule

//--- sources.f
source/rv32i_types.sv
source/dmem_if.sv
source/agu.sv
source/memory_queue.sv
source/dcache_port.sv
source/lsq_top.sv
bench/lsq_chk.sv
bench/lsq_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the load/store queue testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module lsq_tb -f sources.f --Mdir obj_dir -o lsq_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/lsq_sim +verilator+error+limit+100 > "$log" 2>&1
status=$?
cat "$log"

if [ $status -ne 0 ]; then
    echo "FAIL: simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" "$log"; then
    echo "PASS"
    exit 0
fi

echo "FAIL: pass message not found in $log"
exit 1
